/* source/cp0_params.svh */
`ifndef CP0_PARAMS_SVH
`define CP0_PARAMS_SVH

// CP0 register addresses are {register number, select}.
`define CP0_ADDR_BADVADDR 8'h40
`define CP0_ADDR_COUNT    8'h48
`define CP0_ADDR_COMPARE  8'h58
`define CP0_ADDR_STATUS   8'h60
`define CP0_ADDR_CAUSE    8'h68
`define CP0_ADDR_EPC      8'h70

`define EXC_INT  5'd0
`define EXC_ADEL 5'd4
`define EXC_SYS  5'd8
`define EXC_BP   5'd9
`define EXC_RI   5'd10

`define EXC_VECTOR 32'hBFC00380

`define OPC_COP0    6'b010000
`define OPC_SPECIAL 6'b000000
`define RS_MF       5'b00000
`define RS_MT       5'b00100
`define RS_CO       5'b10000
`define FN_ERET     6'b011000
`define FN_SYSCALL  6'b001100
`define FN_BREAK    6'b001101

`endif

/* source/cp0_pkg.sv */
package cp0_pkg;

    typedef logic [31:0] word_t;

    // register number in the upper five bits, select in the lower three.
    typedef logic [7:0] cp0_addr_t;

    typedef logic [4:0] exccode_t;

    typedef logic [5:0] irq_t;

    typedef enum logic [2:0] {
        op_nop,
        op_mfc0,
        op_mtc0,
        op_eret,
        op_syscall,
        op_break,
        op_reserved
    } priv_op_t;

    // phases of a four-phase req/ack exchange.
    typedef enum logic [1:0] {
        hs_idle,
        hs_held,
        hs_wait_drop
    } hs_state_t;

endpackage

/* source/cmd_accept.sv */
`timescale 1ns/1ps

module cmd_accept (
    input  logic            clk,
    input  logic            rst,
    input  logic            cmd_req,
    input  cp0_pkg::word_t  cmd_instr,
    input  cp0_pkg::word_t  cmd_pc,
    input  cp0_pkg::word_t  cmd_operand,
    input  logic            cmd_bd,
    output logic            cmd_ack,
    output logic            a_valid,
    output cp0_pkg::word_t  a_instr,
    output cp0_pkg::word_t  a_pc,
    output cp0_pkg::word_t  a_operand,
    output logic            a_bd,
    input  logic            a_ready
);

    cp0_pkg::hs_state_t state;
    logic               capture;

    // a command is only taken when the stage register has room for it.
    assign capture = (state == cp0_pkg::hs_idle) && cmd_req && (!a_valid || a_ready);
    assign cmd_ack = (state == cp0_pkg::hs_held);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= cp0_pkg::hs_idle;
            a_valid <= 1'b0;
        end else if (capture) begin
            state   <= cp0_pkg::hs_held;
            a_valid <= 1'b1;
        end else begin
            if (a_ready)
                a_valid <= 1'b0;
            if (state == cp0_pkg::hs_held && !cmd_req)
                state <= cp0_pkg::hs_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            a_instr   <= cmd_instr;
            a_pc      <= cmd_pc;
            a_operand <= cmd_operand;
            a_bd      <= cmd_bd;
        end
    end

    ack_follows_req: assert property (@(posedge clk) disable iff (rst)
        $rose(cmd_ack) |-> $past(cmd_req));

endmodule

/* source/priv_decode.sv */
`timescale 1ns/1ps
`include "cp0_params.svh"

module priv_decode (
    input  logic                clk,
    input  logic                rst,
    input  logic                a_valid,
    input  cp0_pkg::word_t      a_instr,
    input  cp0_pkg::word_t      a_pc,
    input  cp0_pkg::word_t      a_operand,
    input  logic                a_bd,
    output logic                a_ready,
    output logic                d_valid,
    output cp0_pkg::priv_op_t   d_op,
    output cp0_pkg::cp0_addr_t  d_addr,
    output cp0_pkg::word_t      d_pc,
    output cp0_pkg::word_t      d_operand,
    output logic                d_bd,
    input  logic                d_ready
);

    function automatic cp0_pkg::priv_op_t classify(input cp0_pkg::word_t instr);
        cp0_pkg::priv_op_t op;
        op = cp0_pkg::op_reserved;
        if (instr == 32'h0) begin
            op = cp0_pkg::op_nop;
        end else if (instr[31:26] == `OPC_COP0) begin
            if (instr[25:21] == `RS_MF)
                op = cp0_pkg::op_mfc0;
            else if (instr[25:21] == `RS_MT)
                op = cp0_pkg::op_mtc0;
            else if (instr[25:21] == `RS_CO && instr[5:0] == `FN_ERET)
                op = cp0_pkg::op_eret;
        end else if (instr[31:26] == `OPC_SPECIAL) begin
            if (instr[5:0] == `FN_SYSCALL)
                op = cp0_pkg::op_syscall;
            else if (instr[5:0] == `FN_BREAK)
                op = cp0_pkg::op_break;
        end
        return op;
    endfunction

    assign a_ready = !d_valid || d_ready;

    always_ff @(posedge clk) begin
        if (rst)
            d_valid <= 1'b0;
        else if (a_ready)
            d_valid <= a_valid;
    end

    always_ff @(posedge clk) begin
        if (a_valid && a_ready) begin
            d_op      <= classify(a_instr);
            // rd and sel together form the CP0 address.
            d_addr    <= {a_instr[15:11], a_instr[2:0]};
            d_pc      <= a_pc;
            d_operand <= a_operand;
            d_bd      <= a_bd;
        end
    end

endmodule

/* source/exc_resolve.sv */
`timescale 1ns/1ps
`include "cp0_params.svh"

module exc_resolve (
    input  logic                clk,
    input  logic                rst,
    input  logic                d_valid,
    input  cp0_pkg::priv_op_t   d_op,
    input  cp0_pkg::cp0_addr_t  d_addr,
    input  cp0_pkg::word_t      d_pc,
    input  cp0_pkg::word_t      d_operand,
    input  logic                d_bd,
    output logic                d_ready,
    output logic                rd_ena,
    output cp0_pkg::cp0_addr_t  rd_addr,
    output logic                wr_ena,
    output cp0_pkg::cp0_addr_t  wr_addr,
    output cp0_pkg::word_t      wr_data,
    output logic                exl_clear,
    output logic                exc_take,
    output cp0_pkg::exccode_t   exc_code,
    output logic                exc_bd,
    output cp0_pkg::word_t      exc_epc,
    output logic                badvaddr_load,
    output cp0_pkg::word_t      exc_badvaddr,
    input  cp0_pkg::word_t      rd_data,
    input  cp0_pkg::word_t      epc,
    input  logic                int_pending,
    output logic                r_valid,
    output cp0_pkg::word_t      r_data,
    output logic                r_redirect,
    output cp0_pkg::word_t      r_target,
    input  logic                r_ready
);

    logic consume;
    logic adel_exc;
    logic sw_exc;
    logic any_exc;
    logic do_op;

    assign d_ready  = !r_valid || r_ready;
    assign consume  = d_valid && d_ready;
    assign adel_exc = (d_pc[1:0] != 2'b00);
    assign sw_exc   = d_op inside {cp0_pkg::op_reserved, cp0_pkg::op_syscall,
                                   cp0_pkg::op_break};
    assign any_exc  = int_pending || adel_exc || sw_exc;
    assign do_op    = consume && !any_exc;

    // interrupt first, then the misaligned pc, then the instruction itself.
    always_comb begin
        if (int_pending)
            exc_code = `EXC_INT;
        else if (adel_exc)
            exc_code = `EXC_ADEL;
        else if (d_op == cp0_pkg::op_syscall)
            exc_code = `EXC_SYS;
        else if (d_op == cp0_pkg::op_break)
            exc_code = `EXC_BP;
        else
            exc_code = `EXC_RI;
    end

    assign rd_ena        = do_op && (d_op == cp0_pkg::op_mfc0);
    assign rd_addr       = d_addr;
    assign wr_ena        = do_op && (d_op == cp0_pkg::op_mtc0);
    assign wr_addr       = d_addr;
    assign wr_data       = d_operand;
    assign exl_clear     = do_op && (d_op == cp0_pkg::op_eret);
    assign exc_take      = consume && any_exc;
    assign exc_bd        = d_bd;
    assign exc_epc       = d_bd ? d_pc - 32'd4 : d_pc;
    assign badvaddr_load = exc_take && !int_pending && adel_exc;
    assign exc_badvaddr  = d_pc;

    always_ff @(posedge clk) begin
        if (rst)
            r_valid <= 1'b0;
        else if (d_ready)
            r_valid <= d_valid;
    end

    // cp0 returns zero whenever rd_ena is low.
    always_ff @(posedge clk) begin
        if (consume) begin
            r_data     <= rd_data;
            r_redirect <= any_exc || exl_clear;
            r_target   <= any_exc ? `EXC_VECTOR : epc;
        end
    end

    no_write_on_exception: assert property (@(posedge clk) disable iff (rst)
        !(exc_take && (wr_ena || exl_clear)));

endmodule

/* source/cp0.sv */
`timescale 1ns/1ps
`include "cp0_params.svh"

module cp0 (
    input  logic                clk,
    input  logic                rst,
    input  cp0_pkg::irq_t       interrupt,
    input  logic                rd_ena,
    input  cp0_pkg::cp0_addr_t  rd_addr,
    input  logic                wr_ena,
    input  cp0_pkg::cp0_addr_t  wr_addr,
    input  cp0_pkg::word_t      wr_data,
    input  logic                exl_clear,
    input  logic                exc_take,
    input  cp0_pkg::exccode_t   exc_code,
    input  logic                exc_bd,
    input  cp0_pkg::word_t      exc_epc,
    input  logic                badvaddr_load,
    input  cp0_pkg::word_t      exc_badvaddr,
    output cp0_pkg::word_t      rd_data,
    output cp0_pkg::word_t      epc,
    output logic                int_pending
);

    cp0_pkg::word_t badvaddr;
    cp0_pkg::word_t count;
    cp0_pkg::word_t compare;
    cp0_pkg::word_t status;
    cp0_pkg::word_t cause;
    cp0_pkg::word_t epc_reg;

    assign epc = epc_reg;

    // IE set, EXL clear and some pending line enabled by IM.
    assign int_pending = status[0] && !status[1] && |(status[15:8] & cause[15:8]);

    always_ff @(posedge clk) begin
        if (rst) begin
            badvaddr <= 32'h0;
            count    <= 32'h0;
            compare  <= 32'h0;
            status   <= 32'h0040_0000;
            cause    <= 32'h0;
            epc_reg  <= 32'h0;
        end else begin
            count        <= count + 32'd1;
            // the timer shares the top hardware line.
            cause[15:10] <= {interrupt[5] | cause[30], interrupt[4:0]};

            if (compare != 32'h0 && count == compare)
                cause[30] <= 1'b1;

            if (exl_clear)
                status[1] <= 1'b0;

            if (exc_take) begin
                // a nested exception keeps the first EPC and BD.
                if (!status[1]) begin
                    epc_reg   <= exc_epc;
                    cause[31] <= exc_bd;
                end
                status[1]  <= 1'b1;
                cause[6:2] <= exc_code;
                if (badvaddr_load)
                    badvaddr <= exc_badvaddr;
            end

            if (wr_ena) begin
                case (wr_addr)
                    `CP0_ADDR_COUNT: begin
                        count <= wr_data;
                    end
                    `CP0_ADDR_COMPARE: begin
                        compare   <= wr_data;
                        cause[30] <= 1'b0;
                    end
                    `CP0_ADDR_STATUS: begin
                        status[15:8] <= wr_data[15:8];
                        status[1]    <= wr_data[1];
                        status[0]    <= wr_data[0];
                    end
                    `CP0_ADDR_CAUSE: begin
                        cause[9:8] <= wr_data[9:8];
                    end
                    `CP0_ADDR_EPC: begin
                        epc_reg <= wr_data;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_comb begin
        rd_data = 32'h0;
        if (rd_ena) begin
            case (rd_addr)
                `CP0_ADDR_BADVADDR: rd_data = badvaddr;
                `CP0_ADDR_COUNT:    rd_data = count;
                `CP0_ADDR_COMPARE:  rd_data = compare;
                `CP0_ADDR_STATUS:   rd_data = status;
                `CP0_ADDR_CAUSE:    rd_data = cause;
                `CP0_ADDR_EPC:      rd_data = epc_reg;
                default:            rd_data = 32'h0;
            endcase
        end
    end

endmodule

/* source/resp_send.sv */
`timescale 1ns/1ps

module resp_send (
    input  logic            clk,
    input  logic            rst,
    input  logic            r_valid,
    input  cp0_pkg::word_t  r_data,
    input  logic            r_redirect,
    input  cp0_pkg::word_t  r_target,
    output logic            r_ready,
    output logic            resp_req,
    input  logic            resp_ack,
    output cp0_pkg::word_t  resp_data,
    output logic            resp_redirect,
    output cp0_pkg::word_t  resp_target
);

    cp0_pkg::hs_state_t state;

    assign r_ready  = (state == cp0_pkg::hs_idle);
    assign resp_req = (state == cp0_pkg::hs_held);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cp0_pkg::hs_idle;
        end else begin
            case (state)
                cp0_pkg::hs_idle:
                    if (r_valid)
                        state <= cp0_pkg::hs_held;
                cp0_pkg::hs_held:
                    if (resp_ack)
                        state <= cp0_pkg::hs_wait_drop;
                default:
                    if (!resp_ack)
                        state <= cp0_pkg::hs_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (r_valid && r_ready) begin
            resp_data     <= r_data;
            resp_redirect <= r_redirect;
            resp_target   <= r_target;
        end
    end

    data_stable_while_req: assert property (@(posedge clk) disable iff (rst)
        resp_req && $past(resp_req) |-> $stable(resp_data));

endmodule

/* source/cp0_unit_top.sv */
`timescale 1ns/1ps

module cp0_unit_top (
    input  logic            clk,
    input  logic            rst,
    input  cp0_pkg::irq_t   interrupt,
    input  logic            cmd_req,
    output logic            cmd_ack,
    input  cp0_pkg::word_t  cmd_instr,
    input  cp0_pkg::word_t  cmd_pc,
    input  cp0_pkg::word_t  cmd_operand,
    input  logic            cmd_bd,
    output logic            resp_req,
    input  logic            resp_ack,
    output cp0_pkg::word_t  resp_data,
    output logic            resp_redirect,
    output cp0_pkg::word_t  resp_target
);

    logic                a_valid;
    logic                a_ready;
    cp0_pkg::word_t      a_instr;
    cp0_pkg::word_t      a_pc;
    cp0_pkg::word_t      a_operand;
    logic                a_bd;

    logic                d_valid;
    logic                d_ready;
    cp0_pkg::priv_op_t   d_op;
    cp0_pkg::cp0_addr_t  d_addr;
    cp0_pkg::word_t      d_pc;
    cp0_pkg::word_t      d_operand;
    logic                d_bd;

    logic                rd_ena;
    cp0_pkg::cp0_addr_t  rd_addr;
    cp0_pkg::word_t      rd_data;
    logic                wr_ena;
    cp0_pkg::cp0_addr_t  wr_addr;
    cp0_pkg::word_t      wr_data;
    logic                exl_clear;
    logic                exc_take;
    cp0_pkg::exccode_t   exc_code;
    logic                exc_bd;
    cp0_pkg::word_t      exc_epc;
    logic                badvaddr_load;
    cp0_pkg::word_t      exc_badvaddr;
    cp0_pkg::word_t      epc;
    logic                int_pending;

    logic                r_valid;
    logic                r_ready;
    cp0_pkg::word_t      r_data;
    logic                r_redirect;
    cp0_pkg::word_t      r_target;

    // every link shares its name on both sides, so ports bind implicitly.
    cmd_accept  u_cmd_accept  (.*);
    priv_decode u_priv_decode (.*);
    exc_resolve u_exc_resolve (.*);
    cp0         u_cp0         (.*);
    resp_send   u_resp_send   (.*);

endmodule

/* sim/cp0_unit_tb.sv */
`timescale 1ns/1ps
`include "cp0_params.svh"

module cp0_unit_tb;

    typedef struct packed {
        cp0_pkg::word_t instr;
        cp0_pkg::word_t pc;
        cp0_pkg::word_t operand;
        logic           bd;
        cp0_pkg::irq_t  irq;
        logic           redirect;
        cp0_pkg::word_t target;
        cp0_pkg::word_t data;
        cp0_pkg::word_t mask;
        int             hold;
    } row_t;

    localparam cp0_pkg::cp0_addr_t reg_bva    = `CP0_ADDR_BADVADDR;
    localparam cp0_pkg::cp0_addr_t reg_count  = `CP0_ADDR_COUNT;
    localparam cp0_pkg::cp0_addr_t reg_cmp    = `CP0_ADDR_COMPARE;
    localparam cp0_pkg::cp0_addr_t reg_status = `CP0_ADDR_STATUS;
    localparam cp0_pkg::cp0_addr_t reg_cause  = `CP0_ADDR_CAUSE;
    localparam cp0_pkg::cp0_addr_t reg_epc    = `CP0_ADDR_EPC;
    localparam cp0_pkg::word_t     vec        = `EXC_VECTOR;
    localparam cp0_pkg::word_t     all_bits   = 32'hffffffff;
    // commands issued outside the table, with room to spare.
    localparam int                 extra_cmds = 60;

    logic           clk;
    logic           rst;
    cp0_pkg::irq_t  interrupt;
    logic           cmd_req;
    logic           cmd_ack;
    cp0_pkg::word_t cmd_instr;
    cp0_pkg::word_t cmd_pc;
    cp0_pkg::word_t cmd_operand;
    logic           cmd_bd;
    logic           resp_req;
    logic           resp_ack;
    cp0_pkg::word_t resp_data;
    logic           resp_redirect;
    cp0_pkg::word_t resp_target;

    row_t        rows[$];
    logic        table_ready = 1'b0;
    logic [15:0] lfsr_state  = 16'd26077;
    int          checks       = 0;
    int          value_errors = 0;
    int          other_errors = 0;

    cp0_unit_top u_cp0_unit_top (
        .clk           (clk),
        .rst           (rst),
        .interrupt     (interrupt),
        .cmd_req       (cmd_req),
        .cmd_ack       (cmd_ack),
        .cmd_instr     (cmd_instr),
        .cmd_pc        (cmd_pc),
        .cmd_operand   (cmd_operand),
        .cmd_bd        (cmd_bd),
        .resp_req      (resp_req),
        .resp_ack      (resp_ack),
        .resp_data     (resp_data),
        .resp_redirect (resp_redirect),
        .resp_target   (resp_target)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic cp0_pkg::word_t mfc0_word(input cp0_pkg::cp0_addr_t addr);
        return {`OPC_COP0, `RS_MF, 5'd2, addr[7:3], 8'h00, addr[2:0]};
    endfunction

    function automatic cp0_pkg::word_t mtc0_word(input cp0_pkg::cp0_addr_t addr);
        return {`OPC_COP0, `RS_MT, 5'd3, addr[7:3], 8'h00, addr[2:0]};
    endfunction

    function automatic cp0_pkg::word_t eret_word();
        return {`OPC_COP0, `RS_CO, 15'h0000, `FN_ERET};
    endfunction

    function automatic cp0_pkg::word_t special_word(input logic [5:0] fn);
        return {`OPC_SPECIAL, 20'h00000, fn};
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic next_lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic int random_hold();
        int h;
        h = 0;
        for (int i = 0; i < 3; i++)
            h = (h << 1) | int'(next_lfsr_bit());
        return h;
    endfunction

    function automatic cp0_pkg::word_t burst_value(input int k);
        return 32'h5a000000 + k * 32'h111;
    endfunction

    // the resp_ack hold of each row is drawn as the row is added.
    task automatic add_row(input cp0_pkg::word_t instr, pc, operand, input logic bd,
                           input cp0_pkg::irq_t irq, input logic redirect,
                           input cp0_pkg::word_t target, data, mask);
        int hold;
        hold = random_hold();
        rows.push_back({instr, pc, operand, bd, irq, redirect, target, data, mask, hold});
    endtask

    // columns are instr, pc, operand, bd, irq, redirect, target, data, data mask.
    task automatic build_table();
        add_row(mtc0_word(reg_epc), 32'h80000000, 32'h12345678, 0, 0, 0, 0, 0, 0);
        add_row(mfc0_word(reg_epc), 32'h80000004, 0, 0, 0, 0, 0, 32'h12345678, all_bits);
        add_row(mtc0_word(reg_status), 32'h80000008, 32'hffffff00, 0, 0, 0, 0, 0, 0);
        add_row(mfc0_word(reg_status), 32'h8000000c, 0, 0, 0, 0, 0, 32'h0040ff00, all_bits);
        add_row(mtc0_word(reg_cmp), 32'h80000010, 32'hcafe0000, 0, 0, 0, 0, 0, 0);
        add_row(mfc0_word(reg_cmp), 32'h80000014, 0, 0, 0, 0, 0, 32'hcafe0000, all_bits);
        add_row(mfc0_word(8'h78), 32'h80000018, 0, 0, 0, 0, 0, 32'h0, all_bits);
        add_row(32'h0, 32'h80000020, 0, 0, 0, 0, 0, 0, 0);
        add_row(special_word(`FN_SYSCALL), 32'h80001000, 0, 0, 0, 1, vec, 0, 0);
        add_row(mfc0_word(reg_cause), 32'h80001004, 0, 0, 0, 0, 0, 32'h20, 32'h8000007c);
        add_row(mfc0_word(reg_epc), 32'h80001008, 0, 0, 0, 0, 0, 32'h80001000, all_bits);
        add_row(eret_word(), 32'h8000100c, 0, 0, 0, 1, 32'h80001000, 0, 0);
        add_row(mfc0_word(reg_status), 32'h80001010, 0, 0, 0, 0, 0, 32'h0040ff00, all_bits);
        add_row(special_word(`FN_BREAK), 32'h80002004, 0, 1, 0, 1, vec, 0, 0);
        add_row(mfc0_word(reg_cause), 32'h80002008, 0, 0, 0, 0, 0, 32'h80000024, 32'h8000007c);
        add_row(mfc0_word(reg_epc), 32'h8000200c, 0, 0, 0, 0, 0, 32'h80002000, all_bits);
        // EXL is still set, so EPC and BD must survive this one.
        add_row(32'hffffffff, 32'h80003000, 0, 0, 0, 1, vec, 0, 0);
        add_row(mfc0_word(reg_cause), 32'h80003004, 0, 0, 0, 0, 0, 32'h80000028, 32'h8000007c);
        add_row(mfc0_word(reg_epc), 32'h80003008, 0, 0, 0, 0, 0, 32'h80002000, all_bits);
        add_row(eret_word(), 32'h8000300c, 0, 0, 0, 1, 32'h80002000, 0, 0);
        add_row(32'h0, 32'h80004002, 0, 0, 0, 1, vec, 0, 0);
        add_row(mfc0_word(reg_cause), 32'h80004004, 0, 0, 0, 0, 0, 32'h10, 32'h8000007c);
        add_row(mfc0_word(reg_bva), 32'h80004008, 0, 0, 0, 0, 0, 32'h80004002, all_bits);
        add_row(mfc0_word(reg_epc), 32'h8000400c, 0, 0, 0, 0, 0, 32'h80004002, all_bits);
        add_row(eret_word(), 32'h80004010, 0, 0, 0, 1, 32'h80004002, 0, 0);
        add_row(mtc0_word(reg_status), 32'h80004014, 32'h00000401, 0, 0, 0, 0, 0, 0);
        add_row(32'h0, 32'h80005000, 0, 0, 6'h01, 1, vec, 0, 0);
        add_row(mfc0_word(reg_cause), 32'h80005004, 0, 0, 6'h01, 0, 0, 32'h400, 32'h8000fc7c);
        add_row(mfc0_word(reg_epc), 32'h80005008, 0, 0, 6'h01, 0, 0, 32'h80005000, all_bits);
        add_row(eret_word(), 32'h80005010, 0, 0, 0, 1, 32'h80005000, 0, 0);
        add_row(mfc0_word(reg_status), 32'h80005014, 0, 0, 0, 0, 0, 32'h00400401, all_bits);
        add_row(mtc0_word(reg_status), 32'h80005018, 32'h0, 0, 0, 0, 0, 0, 0);
        add_row(mfc0_word(reg_status), 32'h8000501c, 0, 0, 0, 0, 0, 32'h00400000, all_bits);
    endtask

    task automatic send_cmd(input cp0_pkg::word_t instr, pc, operand, input logic bd);
        cmd_instr   = instr;
        cmd_pc      = pc;
        cmd_operand = operand;
        cmd_bd      = bd;
        cmd_req     = 1'b1;
        do begin
            @(posedge clk);
            #2;
        end while (!cmd_ack);
        cmd_req = 1'b0;
        do begin
            @(posedge clk);
            #2;
        end while (cmd_ack);
    endtask

    task automatic get_resp(input int hold, output cp0_pkg::word_t data,
                            output logic redirect, output cp0_pkg::word_t target);
        while (!resp_req) begin
            @(posedge clk);
            #2;
        end
        data     = resp_data;
        redirect = resp_redirect;
        target   = resp_target;
        repeat (hold) begin
            @(posedge clk);
            #2;
        end
        resp_ack = 1'b1;
        do begin
            @(posedge clk);
            #2;
        end while (resp_req);
        resp_ack = 1'b0;
    endtask

    task automatic exchange(input cp0_pkg::word_t instr, pc, operand, input logic bd,
                            output cp0_pkg::word_t data, output logic redirect,
                            output cp0_pkg::word_t target);
        send_cmd(instr, pc, operand, bd);
        get_resp(random_hold(), data, redirect, target);
    endtask

    task automatic expect_word(input string name, input cp0_pkg::word_t got, exp);
        checks++;
        assert (got === exp) else begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_row(input row_t r, input cp0_pkg::word_t data,
                             input logic redirect, input cp0_pkg::word_t target);
        expect_word("resp_redirect", {31'b0, redirect}, {31'b0, r.redirect});
        if (r.redirect)
            expect_word("resp_target", target, r.target);
        if (r.mask != 32'h0)
            expect_word("resp_data", data & r.mask, r.data);
    endtask

    task automatic count_check();
        cp0_pkg::word_t c1;
        cp0_pkg::word_t c2;
        cp0_pkg::word_t t;
        logic           redir;
        exchange(mfc0_word(reg_count), 32'h80006000, 0, 0, c1, redir, t);
        exchange(mfc0_word(reg_count), 32'h80006004, 0, 0, c2, redir, t);
        checks++;
        assert (c2 > c1) else begin
            value_errors++;
            $display("CHECK FAILED at %0t: resp_data (Count) got %h expected above %h",
                     $time, c2, c1);
        end
    endtask

    task automatic timer_check();
        cp0_pkg::word_t c;
        cp0_pkg::word_t d;
        cp0_pkg::word_t t;
        logic           redir;
        logic           seen;
        int             n;
        exchange(mfc0_word(reg_count), 32'h80006100, 0, 0, c, redir, t);
        exchange(mtc0_word(reg_cmp), 32'h80006104, c + 32'd60, 0, d, redir, t);
        exchange(mtc0_word(reg_status), 32'h80006108, 32'h00008001, 0, d, redir, t);
        seen = 1'b0;
        n    = 0;
        while (!seen && n < 20) begin
            exchange(32'h0, 32'h80006200 + n * 4, 0, 0, d, redir, t);
            seen = redir;
            n++;
        end
        checks++;
        assert (seen) else begin
            other_errors++;
            $display("the timer interrupt was not taken within 20 commands");
        end
        if (seen) begin
            expect_word("resp_target", t, vec);
            exchange(mfc0_word(reg_cause), 32'h80006300, 0, 0, d, redir, t);
            expect_word("resp_data (Cause)", d & 32'h4000807c, 32'h40008000);
        end
        exchange(mtc0_word(reg_status), 32'h80006304, 32'h0, 0, d, redir, t);
        exchange(mtc0_word(reg_cmp), 32'h80006308, 32'h0, 0, d, redir, t);
    endtask

    // commands stream in back to back while responses drain at random pace.
    task automatic burst_check();
        cp0_pkg::word_t d;
        cp0_pkg::word_t t;
        logic           redir;
        fork
            begin
                for (int k = 0; k < 8; k++) begin
                    send_cmd(mtc0_word(reg_epc), 32'h80007000 + k * 8, burst_value(k), 0);
                    send_cmd(mfc0_word(reg_epc), 32'h80007004 + k * 8, 0, 0);
                end
            end
            begin
                for (int k = 0; k < 16; k++) begin
                    get_resp(random_hold(), d, redir, t);
                    expect_word("resp_redirect", {31'b0, redir}, 32'h0);
                    if (k % 2 == 1)
                        expect_word("resp_data (EPC)", d, burst_value(k / 2));
                end
            end
        join
    endtask

    initial begin
        wait (table_ready);
        repeat ((rows.size() + extra_cmds) * 40) @(posedge clk);
        $display("timeout: the host handshakes did not complete in time");
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors + 1);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        cp0_pkg::word_t d;
        cp0_pkg::word_t t;
        logic           redir;
        rst         = 1'b1;
        interrupt   = 6'h00;
        cmd_req     = 1'b0;
        cmd_instr   = 32'h0;
        cmd_pc      = 32'h0;
        cmd_operand = 32'h0;
        cmd_bd      = 1'b0;
        resp_ack    = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;
        foreach (rows[i]) begin
            interrupt = rows[i].irq;
            send_cmd(rows[i].instr, rows[i].pc, rows[i].operand, rows[i].bd);
            get_resp(rows[i].hold, d, redir, t);
            check_row(rows[i], d, redir, t);
        end
        interrupt = 6'h00;
        count_check();
        timer_check();
        burst_check();
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* cp0_unit_top.f */
+incdir+source
source/cp0_pkg.sv
source/cmd_accept.sv
source/priv_decode.sv
source/exc_resolve.sv
source/cp0.sv
source/resp_send.sv
source/cp0_unit_top.sv
sim/cp0_unit_tb.sv

/* Makefile */
# Verilator flow for the CP0 unit.
VERILATOR ?= verilator
FILELIST  ?= cp0_unit_top.f
TB_TOP    ?= cp0_unit_tb
RTL_TOP   ?= cp0_unit_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
